// File: common/ciPkg.sv
`default_nettype none

package ciPkg;

  typedef logic [31:0] wordT;
  typedef logic [7:0]  ciIdT;
  typedef logic [15:0] rgb565T;        // Red 15:11, green 10:5, blue 4:0
  typedef logic [7:0]  grayT;
  typedef logic [1:0]  counterIndexT;

  // Processor side of a custom instruction
  typedef struct packed {
    logic start;                       // One-cycle strobe
    ciIdT n;
    wordT dataA;
    wordT dataB;
  } ciRequestT;

  // Unit side, ORed over all units
  typedef struct packed {
    logic done;
    wordT result;
  } ciResponseT;

  localparam ciIdT cSwapByteId  = 8'd1;
  localparam ciIdT cProfileId   = 8'd8;
  localparam ciIdT cGrayscaleId = 8'd12;

  // Top bit of the lock counter releases the system
  localparam int cResetCountWidth = 5;

  // Cycles, stalled cycles, bus-idle cycles
  localparam int cNumCounters = 3;

  // Luminance weights in 1/256 steps, summing to 256
  localparam logic [7:0] cRedWeight   = 8'd54;
  localparam logic [7:0] cGreenWeight = 8'd183;
  localparam logic [7:0] cBlueWeight  = 8'd19;

endpackage

`default_nettype wire

// File: rtl/resetSequencer.sv
`default_nettype none

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset
);

  import ciPkg::*;

  logic [cResetCountWidth-1:0] lockCount;
  logic                        lockDone;

  assign lockDone = lockCount[cResetCountWidth-1];

  // Saturates once the top bit is reached
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCount <= '0;
    end else if (!lockDone) begin
      lockCount <= lockCount + (cResetCountWidth)'(1);
    end
  end

  assign systemReset = ~lockDone;  // High until 16 locked edges

endmodule

`default_nettype wire

// File: rtl/dataFormatCi.sv
`default_nettype none

module dataFormatCi (
  input  ciPkg::ciRequestT  ciRequest,
  output ciPkg::ciResponseT ciResponse
);

  import ciPkg::*;

  logic        swapSelect;
  logic        graySelect;
  wordT        swapped;
  rgb565T      pixel;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;
  grayT        gray;

  assign swapSelect = ciRequest.start && (ciRequest.n == cSwapByteId);
  assign graySelect = ciRequest.start && (ciRequest.n == cGrayscaleId);

  // Byte order reversal
  assign swapped = {ciRequest.dataA[7:0],
                    ciRequest.dataA[15:8],
                    ciRequest.dataA[23:16],
                    ciRequest.dataA[31:24]};

  // Upper half of dataA is ignored
  assign pixel = ciRequest.dataA[15:0];

  // Channels scaled up to 8 bits
  assign red   = {pixel[15:11], 3'b000};
  assign green = {pixel[10:5], 2'b00};
  assign blue  = {pixel[4:0], 3'b000};

  // Max is 255 * 256, so 16 bits never overflow
  assign weightedSum = 16'(red) * 16'(cRedWeight) +
                       16'(green) * 16'(cGreenWeight) +
                       16'(blue) * 16'(cBlueWeight);

  assign gray = weightedSum[15:8];

  always_comb begin
    ciResponse = '0;
    if (swapSelect) begin
      ciResponse.done   = 1'b1;
      ciResponse.result = swapped;
    end else if (graySelect) begin
      ciResponse.done   = 1'b1;
      ciResponse.result = {24'd0, gray};
    end
  end

endmodule

`default_nettype wire

// File: profiling/profileCi.sv
`default_nettype none

module profileCi (
  input  logic              s_systemClock,
  input  logic              systemReset,
  input  ciPkg::ciRequestT  ciRequest,
  input  logic              stall,
  input  logic              busIdle,
  output ciPkg::ciResponseT ciResponse
);

  import ciPkg::*;

  logic                    select;
  logic [cNumCounters-1:0] enableSet;
  logic [cNumCounters-1:0] enableClear;
  logic [cNumCounters-1:0] counterClear;
  logic [cNumCounters-1:0] counterEnable;
  logic [cNumCounters-1:0] countCondition;
  wordT                    counters [cNumCounters];
  counterIndexT            readIndex;
  wordT                    readValue;

  assign select = ciRequest.start && (ciRequest.n == cProfileId);

  // Control fields of dataB, only on our own instruction
  assign enableSet    = select ? ciRequest.dataB[0 +: cNumCounters] : '0;
  assign enableClear  = select ? ciRequest.dataB[4 +: cNumCounters] : '0;
  assign counterClear = select ? ciRequest.dataB[8 +: cNumCounters] : '0;

  // Counter 0 runs every cycle
  assign countCondition = {busIdle, stall, 1'b1};

  // Disable beats enable when both are given
  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      counterEnable <= '0;
    end else begin
      counterEnable <= (counterEnable | enableSet) & ~enableClear;
    end
  end

  for (genvar i = 0; i < cNumCounters; i++) begin : gCounter
    always_ff @(posedge s_systemClock or posedge systemReset) begin
      if (systemReset) begin
        counters[i] <= '0;
      end else if (counterClear[i]) begin
        counters[i] <= '0;                               // Clear wins over counting
      end else if (counterEnable[i] && !enableClear[i] && countCondition[i]) begin
        counters[i] <= counters[i] + 32'd1;              // Stops at the disabling edge
      end
    end
  end

  assign readIndex = ciRequest.dataA[1:0];

  // Unused index reads as zero
  always_comb begin
    readValue = '0;
    for (int i = 0; i < cNumCounters; i++) begin
      if (readIndex == counterIndexT'(i)) begin
        readValue = counters[i];
      end
    end
  end

  // Value before the edge that ends the read cycle
  always_comb begin
    ciResponse = '0;
    if (select) begin
      ciResponse.done   = 1'b1;
      ciResponse.result = readValue;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ciCluster.sv
`default_nettype none

module ciCluster (
  input  logic              s_systemClock,
  input  logic              s_pllLocked,
  input  ciPkg::ciRequestT  ciRequest,
  input  logic              stall,
  input  logic              busIdle,
  output ciPkg::ciResponseT ciResponse,
  output logic              systemReset
);

  import ciPkg::*;

  ciResponseT dataFormatResponse;
  ciResponseT profileResponse;

  resetSequencer resetSequencer0 (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReset   (systemReset)
  );

  // Byte swap and grayscale, no state
  dataFormatCi dataFormat0 (
    .ciRequest  (ciRequest),
    .ciResponse (dataFormatResponse)
  );

  profileCi profile0 (
    .s_systemClock (s_systemClock),
    .systemReset   (systemReset),
    .ciRequest     (ciRequest),
    .stall         (stall),
    .busIdle       (busIdle),
    .ciResponse    (profileResponse)
  );

  // Idle units drive zeros, so a plain OR merges them
  assign ciResponse.done   = dataFormatResponse.done | profileResponse.done;
  assign ciResponse.result = dataFormatResponse.result | profileResponse.result;

endmodule

`default_nettype wire

// File: sim/ciCluster_assertions.sv
`default_nettype none

module ciCluster_assertions (
  input logic              s_systemClock,
  input logic              s_pllLocked,
  input ciPkg::ciRequestT  ciRequest,
  input ciPkg::ciResponseT ciResponse,
  input logic              systemReset
);

  timeunit 1ns;
  timeprecision 1ps;

  // Units answer only in the start cycle
  doneNeedsStart: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      ciResponse.done |-> ciRequest.start
  ) else $error("done high without start");

  resultZeroWhenIdle: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      !ciResponse.done |-> (ciResponse.result == '0)
  ) else $error("result nonzero while done is low");

  // Released for good while the PLL stays locked
  resetStaysReleased: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      !systemReset |=> !systemReset
  ) else $error("systemReset rose again while locked");

endmodule

bind ciCluster ciCluster_assertions assertions0 (
  .s_systemClock (s_systemClock),
  .s_pllLocked   (s_pllLocked),
  .ciRequest     (ciRequest),
  .ciResponse    (ciResponse),
  .systemReset   (systemReset)
);

`default_nettype wire

// File: sim/ciClusterTb.sv
`default_nettype none

module ciClusterTb;

  timeunit 1ns;
  timeprecision 1ps;

  import ciPkg::*;

  localparam int cHalfPeriod    = 20;
  localparam int cClockPeriod   = 2 * cHalfPeriod;
  localparam int cResetCycles   = 5;
  localparam int cLockEdges     = 16;   // Lock to release latency
  localparam int cRandomCount   = 20;
  localparam int cWaitCycles    = 25;
  localparam int cLevelCycles   = 50;
  localparam int cMarginCycles  = 60;
  localparam int cTestCycles    = 1 + cResetCycles + cLockEdges + 3 + 2 * cRandomCount + 3 +
                                  (2 * cWaitCycles + 5) + (cLevelCycles + 4);
  localparam int cTimeoutCycles = cTestCycles + cMarginCycles;

  logic       s_systemClock;
  logic       s_pllLocked;
  ciRequestT  ciRequest;
  logic       stall;
  logic       busIdle;
  ciResponseT ciResponse;
  logic       systemReset;
  int         seed;

  ciCluster dut0 (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciRequest     (ciRequest),
    .stall         (stall),
    .busIdle       (busIdle),
    .ciResponse    (ciResponse),
    .systemReset   (systemReset)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #cHalfPeriod s_systemClock = ~s_systemClock;
  end

  initial begin
    #(cTimeoutCycles * cClockPeriod);
    $display("Watchdog expired: the tests did not finish within %0d clock cycles",
             cTimeoutCycles);
    abortRun();
  end

  task automatic abortRun();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic compareWord(input wordT actual, input wordT expected, input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s: got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      abortRun();
    end
  endtask

  task automatic compareBit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s: got %b, expected %b", $time, what, actual, expected);
      abortRun();
    end
  endtask

  task automatic nextCycles(input int count);
    repeat (count) @(negedge s_systemClock);
  endtask

  // Called on a falling edge, returns on the next one with start low
  task automatic issueInstruction(input ciIdT id, input wordT operandA, input wordT operandB,
                                  output ciResponseT response);
    ciRequest.start = 1'b1;
    ciRequest.n     = id;
    ciRequest.dataA = operandA;
    ciRequest.dataB = operandB;
    #5;
    response = ciResponse;
    @(negedge s_systemClock);
    ciRequest = '0;
  endtask

  function automatic wordT expectedGray(input rgb565T pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return wordT'((red * int'(cRedWeight) + green * int'(cGreenWeight) +
                   blue * int'(cBlueWeight)) / 256);
  endfunction

  task automatic checkReset();
    // Drop at the first falling edge so the asynchronous clear sees an edge
    @(negedge s_systemClock);
    s_pllLocked = 1'b0;
    nextCycles(cResetCycles);
    compareBit(systemReset, 1'b1, "systemReset while PLL unlocked");
    s_pllLocked = 1'b1;
    for (int edgeCount = 0; edgeCount < cLockEdges; edgeCount++) begin
      compareBit(systemReset, 1'b1, "systemReset before lock count completes");
      nextCycles(1);
    end
    compareBit(systemReset, 1'b0, "systemReset after lock count");
    compareBit(ciResponse.done, 1'b0, "done while idle");
    nextCycles(2);
    compareBit(systemReset, 1'b0, "systemReset stays low");
    compareBit(ciResponse.done, 1'b0, "done while idle");
  endtask

  task automatic checkByteSwap();
    wordT       operand;
    wordT       expected;
    ciResponseT response;
    for (int i = 0; i < cRandomCount; i++) begin
      operand = $random(seed);
      // Byte b of the result is byte 3 - b of the operand
      for (int b = 0; b < 4; b++) begin
        expected[8*b +: 8] = operand[8*(3-b) +: 8];
      end
      issueInstruction(cSwapByteId, operand, $random(seed), response);
      compareBit(response.done, 1'b1, "byte swap done");
      compareWord(response.result, expected, "byte swap result");
    end
  endtask

  task automatic checkGrayscale();
    rgb565T     fixedPixels [5] = '{16'hF800, 16'h07E0, 16'h001F, 16'hFFFF, 16'h0000};
    rgb565T     pixel;
    wordT       randomWord;
    ciResponseT response;
    for (int i = 0; i < cRandomCount; i++) begin
      randomWord = $random(seed);
      pixel      = (i < 5) ? fixedPixels[i] : randomWord[15:0];
      // Random upper half must not matter
      issueInstruction(cGrayscaleId, {randomWord[31:16], pixel}, 32'd0, response);
      compareBit(response.done, 1'b1, "grayscale done");
      compareWord(response.result, expectedGray(pixel), "grayscale result");
    end
  endtask

  task automatic checkUnknownIds();
    ciIdT       unknownIds [3] = '{8'd0, 8'd4, 8'd200};
    ciResponseT response;
    foreach (unknownIds[i]) begin
      issueInstruction(unknownIds[i], $random(seed), $random(seed), response);
      compareBit(response.done, 1'b0, "done on unknown id");
      compareWord(response.result, 32'd0, "result on unknown id");
    end
  endtask

  task automatic checkCycleCounter();
    ciResponseT response;
    issueInstruction(cProfileId, 32'd0, 32'h0000_0101, response);  // Clear and enable 0
    compareBit(response.done, 1'b1, "profile control done");
    nextCycles(cWaitCycles);
    issueInstruction(cProfileId, 32'd0, 32'h0000_0010, response);  // Read and disable 0
    compareWord(response.result, wordT'(cWaitCycles), "cycle count while enabled");
    nextCycles(cWaitCycles);
    issueInstruction(cProfileId, 32'd0, 32'd0, response);
    compareWord(response.result, wordT'(cWaitCycles), "cycle count after disable");
    issueInstruction(cProfileId, 32'd0, 32'h0000_0100, response);
    issueInstruction(cProfileId, 32'd0, 32'd0, response);
    compareWord(response.result, 32'd0, "cycle count after clear");
  endtask

  task automatic checkLevelCounters();
    ciResponseT response;
    wordT       randomWord;
    int         stallEdges;
    int         idleEdges;
    stallEdges = 0;
    idleEdges  = 0;
    issueInstruction(cProfileId, 32'd0, 32'h0000_0606, response);  // Clear and enable 1, 2
    for (int i = 0; i < cLevelCycles; i++) begin
      randomWord = $random(seed);
      stall      = randomWord[0];
      busIdle    = randomWord[1];
      if (stall) begin
        stallEdges++;
      end
      if (busIdle) begin
        idleEdges++;
      end
      nextCycles(1);
    end
    stall   = 1'b0;
    busIdle = 1'b0;
    issueInstruction(cProfileId, 32'd1, 32'd0, response);
    compareWord(response.result, wordT'(stallEdges), "stall count");
    issueInstruction(cProfileId, 32'd2, 32'd0, response);
    compareWord(response.result, wordT'(idleEdges), "bus-idle count");
    issueInstruction(cProfileId, 32'd3, 32'd0, response);
    compareBit(response.done, 1'b1, "done on unused index");
    compareWord(response.result, 32'd0, "unused counter index");
  endtask

  initial begin
    seed        = 95782;
    s_pllLocked = 1'b1;
    ciRequest   = '0;
    stall       = 1'b0;
    busIdle     = 1'b0;
    checkReset();
    checkByteSwap();
    checkGrayscale();
    checkUnknownIds();
    checkCycleCounter();
    checkLevelCounters();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/ciPkg.sv
rtl/resetSequencer.sv
rtl/dataFormatCi.sv
profiling/profileCi.sv
rtl/ciCluster.sv
sim/ciCluster_assertions.sv
sim/ciClusterTb.sv

// File: Makefile
# Verilator build and run for the ciCluster testbench

TOP      ?= ciClusterTb
FILELIST ?= tb.f
LOG      ?= sim.log
OBJDIR   ?= obj_dir
VFLAGS   ?= --binary --timing --assert --timescale 1ns/1ps -j 0

PASS_TEXT := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables (override on the command line):"
	@echo "  TOP=$(TOP) FILELIST=$(FILELIST) LOG=$(LOG) OBJDIR=$(OBJDIR)"
	@echo "  VFLAGS=$(VFLAGS)"

test:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -F -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
